/* Makefile */
TOP = rob_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f design/*.sv verification/*.sv
	verilator --binary --timing -f files.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only -Wall --timing -f files.f --top-module reorder_buffer

clean:
	rm -rf obj_dir

/* design/reorder_buffer.sv */
/*
  Two-wide reorder buffer. Tags are entry indices, NUM_ENTRIES >= 4.
  Retirement is never stalled, and dispatch is ignored while rob_full is high.
*/
module reorder_buffer #(
  parameter int NUM_ENTRIES = 32,
  localparam int TAG_W = $clog2(NUM_ENTRIES)
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  inst1_valid,
  input  rob_pkg::arch_reg_t    inst1_dest,
  input  logic                  inst2_valid,
  input  rob_pkg::arch_reg_t    inst2_dest,
  input  logic [TAG_W-1:0]      inst1_rega_tag,
  input  logic [TAG_W-1:0]      inst1_regb_tag,
  input  logic [TAG_W-1:0]      inst2_rega_tag,
  input  logic [TAG_W-1:0]      inst2_regb_tag,
  input  logic                  cdb1_valid,
  input  logic [TAG_W-1:0]      cdb1_tag,
  input  rob_pkg::word_t        cdb1_value,
  input  rob_pkg::branch_kind_t cdb1_branch,
  input  logic                  cdb1_mispredicted,
  input  logic                  cdb2_valid,
  input  logic [TAG_W-1:0]      cdb2_tag,
  input  rob_pkg::word_t        cdb2_value,
  input  rob_pkg::branch_kind_t cdb2_branch,
  input  logic                  cdb2_mispredicted,
  output logic [TAG_W-1:0]      inst1_tag,
  output logic                  inst1_tag_valid,
  output logic [TAG_W-1:0]      inst2_tag,
  output logic                  inst2_tag_valid,
  output rob_pkg::word_t        inst1_rega_value,
  output rob_pkg::word_t        inst1_regb_value,
  output rob_pkg::word_t        inst2_rega_value,
  output rob_pkg::word_t        inst2_regb_value,
  output logic                  retire1_valid,
  output logic [TAG_W-1:0]      retire1_tag,
  output rob_pkg::arch_reg_t    retire1_dest,
  output rob_pkg::word_t        retire1_value,
  output rob_pkg::branch_kind_t retire1_branch,
  output logic                  retire1_mispredicted,
  output logic                  retire2_valid,
  output logic [TAG_W-1:0]      retire2_tag,
  output rob_pkg::arch_reg_t    retire2_dest,
  output rob_pkg::word_t        retire2_value,
  output rob_pkg::branch_kind_t retire2_branch,
  output logic                  retire2_mispredicted,
  output logic                  rob_full,
  output logic                  rob_empty
);

  logic [TAG_W-1:0] head;

  rob_cdb_if #(.NUM_ENTRIES(NUM_ENTRIES)) cdb1_bus ();
  rob_cdb_if #(.NUM_ENTRIES(NUM_ENTRIES)) cdb2_bus ();
  rob_ctrl_if #(.NUM_ENTRIES(NUM_ENTRIES)) ctrl_bus ();

  assign cdb1_bus.valid        = cdb1_valid;
  assign cdb1_bus.tag          = cdb1_tag;
  assign cdb1_bus.value        = cdb1_value;
  assign cdb1_bus.branch       = cdb1_branch;
  assign cdb1_bus.mispredicted = cdb1_mispredicted;
  assign cdb2_bus.valid        = cdb2_valid;
  assign cdb2_bus.tag          = cdb2_tag;
  assign cdb2_bus.value        = cdb2_value;
  assign cdb2_bus.branch       = cdb2_branch;
  assign cdb2_bus.mispredicted = cdb2_mispredicted;

  rob_entry_array #(.NUM_ENTRIES(NUM_ENTRIES)) u_entry_array (
    .clock(clock), .reset(reset), .cdb1(cdb1_bus), .cdb2(cdb2_bus), .ctrl(ctrl_bus),
    .head(head),
    .inst1_rega_tag(inst1_rega_tag), .inst1_regb_tag(inst1_regb_tag),
    .inst2_rega_tag(inst2_rega_tag), .inst2_regb_tag(inst2_regb_tag),
    .inst1_rega_value(inst1_rega_value), .inst1_regb_value(inst1_regb_value),
    .inst2_rega_value(inst2_rega_value), .inst2_regb_value(inst2_regb_value),
    .retire1_dest(retire1_dest), .retire1_value(retire1_value),
    .retire1_branch(retire1_branch), .retire1_mispredicted(retire1_mispredicted),
    .retire2_dest(retire2_dest), .retire2_value(retire2_value),
    .retire2_branch(retire2_branch), .retire2_mispredicted(retire2_mispredicted)
  );

  rob_pointer_control #(.NUM_ENTRIES(NUM_ENTRIES)) u_pointer_control (
    .clock(clock), .reset(reset),
    .inst1_valid(inst1_valid), .inst2_valid(inst2_valid),
    .inst1_dest(inst1_dest), .inst2_dest(inst2_dest),
    .head(head), .inst1_tag(inst1_tag), .inst2_tag(inst2_tag),
    .inst1_tag_valid(inst1_tag_valid), .inst2_tag_valid(inst2_tag_valid),
    .retire1_valid(retire1_valid), .retire2_valid(retire2_valid),
    .retire1_tag(retire1_tag), .retire2_tag(retire2_tag),
    .rob_full(rob_full), .rob_empty(rob_empty), .ctrl(ctrl_bus)
  );

endmodule

/* design/rob_cdb_if.sv */
/*
  One CDB result broadcast. The tag is the buffer entry index.
  Fields other than valid are ignored while valid is low.
*/
interface rob_cdb_if #(
  parameter int NUM_ENTRIES = 32,
  localparam int TAG_W = $clog2(NUM_ENTRIES)
);

  logic                  valid;
  logic [TAG_W-1:0]      tag;
  rob_pkg::word_t        value;
  rob_pkg::branch_kind_t branch;
  logic                  mispredicted;

  // buffer entries only listen
  modport receive (
    input valid,
    input tag,
    input value,
    input branch,
    input mispredicted
  );

endinterface

/* design/rob_ctrl_if.sv */
/*
  Link between pointer control and the entry array.
  Slot and retire enables act at the next clock edge.
*/
interface rob_ctrl_if #(
  parameter int NUM_ENTRIES = 32,
  localparam int TAG_W = $clog2(NUM_ENTRIES)
);

  // dispatch slots, slot 1 is older
  logic               slot1_en;
  logic [TAG_W-1:0]   slot1_tag;
  rob_pkg::arch_reg_t slot1_dest;
  logic               slot2_en;
  logic [TAG_W-1:0]   slot2_tag;
  rob_pkg::arch_reg_t slot2_dest;
  logic               retire1_en;
  logic               retire2_en;

  // entry status back to control
  rob_pkg::entry_state_t states [NUM_ENTRIES];
  rob_pkg::branch_kind_t head_branch;
  logic                  head_mispredicted;
  rob_pkg::branch_kind_t next_branch;
  logic                  next_mispredicted;

  modport ctrl (
    output slot1_en, slot1_tag, slot1_dest, slot2_en, slot2_tag, slot2_dest,
    output retire1_en, retire2_en,
    input  states, head_branch, head_mispredicted, next_branch, next_mispredicted
  );

  modport array (
    input  slot1_en, slot1_tag, slot1_dest, slot2_en, slot2_tag, slot2_dest,
    input  retire1_en, retire2_en,
    output states, head_branch, head_mispredicted, next_branch, next_mispredicted
  );

endinterface

/* design/rob_entry.sv */
/*
  A single reorder buffer entry. The tag input must be the entry's own index.
  CDB results count only while the entry is in use, and port 1 wins a tie.
*/
module rob_entry #(
  parameter int NUM_ENTRIES = 32,
  localparam int TAG_W = $clog2(NUM_ENTRIES)
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  clear,
  input  logic                  write,
  input  logic [TAG_W-1:0]      tag,
  input  rob_pkg::arch_reg_t    register_in,
  rob_cdb_if.receive            cdb1,
  rob_cdb_if.receive            cdb2,
  output rob_pkg::entry_state_t state,
  output rob_pkg::arch_reg_t    register_out,
  output rob_pkg::word_t        value,
  output rob_pkg::branch_kind_t branch,
  output logic                  mispredicted
);

  rob_pkg::word_t        stored_value;
  logic                  in_use;
  logic                  cdb1_hit;
  logic                  cdb2_hit;
  logic                  cdb_hit;
  rob_pkg::word_t        cdb_value;
  rob_pkg::branch_kind_t cdb_branch;
  logic                  cdb_mispredicted;

  assign in_use   = (state == rob_pkg::ROBE_INUSE) && !write;
  assign cdb1_hit = in_use && cdb1.valid && (cdb1.tag == tag);
  assign cdb2_hit = in_use && cdb2.valid && (cdb2.tag == tag);
  assign cdb_hit  = cdb1_hit || cdb2_hit;

  // port 1 has priority when both ports hit
  assign cdb_value        = cdb1_hit ? cdb1.value : cdb2.value;
  assign cdb_branch       = cdb1_hit ? cdb1.branch : cdb2.branch;
  assign cdb_mispredicted = cdb1_hit ? cdb1.mispredicted : cdb2.mispredicted;

  // operand reads see a result in the cycle it is broadcast
  assign value = cdb_hit ? cdb_value : stored_value;

  always_ff @(posedge clock)
  begin
    if (reset || clear)
    begin
      state <= rob_pkg::ROBE_EMPTY;
    end
    else if (write)
    begin
      state <= rob_pkg::ROBE_INUSE;
    end
    else if (cdb_hit)
    begin
      state <= rob_pkg::ROBE_COMPLETE;
    end
  end

  always_ff @(posedge clock)
  begin
    if (write)
    begin
      register_out <= register_in;
      stored_value <= '0;
      branch       <= rob_pkg::BRANCH_NONE;
      mispredicted <= 1'b0;
    end
    else if (cdb_hit)
    begin
      stored_value <= cdb_value;
      branch       <= cdb_branch;
      mispredicted <= cdb_mispredicted;
    end
  end

endmodule

/* design/rob_entry_array.sv */
/*
  All buffer entries with their write, clear and read decode.
  Retire data is forced to ZERO_REG and zeros while its enable is low.
*/
module rob_entry_array #(
  parameter int NUM_ENTRIES = 32,
  localparam int TAG_W = $clog2(NUM_ENTRIES)
) (
  input  logic                  clock,
  input  logic                  reset,
  rob_cdb_if.receive            cdb1,
  rob_cdb_if.receive            cdb2,
  rob_ctrl_if.array             ctrl,
  input  logic [TAG_W-1:0]      head,
  input  logic [TAG_W-1:0]      inst1_rega_tag,
  input  logic [TAG_W-1:0]      inst1_regb_tag,
  input  logic [TAG_W-1:0]      inst2_rega_tag,
  input  logic [TAG_W-1:0]      inst2_regb_tag,
  output rob_pkg::word_t        inst1_rega_value,
  output rob_pkg::word_t        inst1_regb_value,
  output rob_pkg::word_t        inst2_rega_value,
  output rob_pkg::word_t        inst2_regb_value,
  output rob_pkg::arch_reg_t    retire1_dest,
  output rob_pkg::word_t        retire1_value,
  output rob_pkg::branch_kind_t retire1_branch,
  output logic                  retire1_mispredicted,
  output rob_pkg::arch_reg_t    retire2_dest,
  output rob_pkg::word_t        retire2_value,
  output rob_pkg::branch_kind_t retire2_branch,
  output logic                  retire2_mispredicted
);

  logic [TAG_W-1:0]       head_plus_one;
  logic [NUM_ENTRIES-1:0] write_en;
  logic [NUM_ENTRIES-1:0] clear_en;
  rob_pkg::arch_reg_t     dest_in [NUM_ENTRIES];
  rob_pkg::entry_state_t  states [NUM_ENTRIES];
  rob_pkg::arch_reg_t     dests [NUM_ENTRIES];
  rob_pkg::word_t         values [NUM_ENTRIES];
  rob_pkg::branch_kind_t  branches [NUM_ENTRIES];
  logic                   mispredicts [NUM_ENTRIES];

  assign head_plus_one = (head == TAG_W'(NUM_ENTRIES - 1)) ? '0 : head + 1'b1;

  for (genvar i = 0; i < NUM_ENTRIES; i++)
  begin : g_entry
    localparam logic [TAG_W-1:0] INDEX = TAG_W'(i);
    logic slot1_here;
    logic slot2_here;

    assign slot1_here  = ctrl.slot1_en && (ctrl.slot1_tag == INDEX);
    assign slot2_here  = ctrl.slot2_en && (ctrl.slot2_tag == INDEX);
    assign write_en[i] = slot1_here || slot2_here;
    assign dest_in[i]  = slot1_here ? ctrl.slot1_dest : ctrl.slot2_dest;
    assign clear_en[i] = (ctrl.retire1_en && (head == INDEX)) ||
                         (ctrl.retire2_en && (head_plus_one == INDEX));

    rob_entry #(.NUM_ENTRIES(NUM_ENTRIES)) u_entry (
      .clock(clock), .reset(reset), .clear(clear_en[i]), .write(write_en[i]),
      .tag(INDEX), .register_in(dest_in[i]), .cdb1(cdb1), .cdb2(cdb2),
      .state(states[i]), .register_out(dests[i]), .value(values[i]),
      .branch(branches[i]), .mispredicted(mispredicts[i])
    );
  end

  ////////////////////////////////////////
  // status back to pointer control
  ////////////////////////////////////////
  assign ctrl.states            = states;
  assign ctrl.head_branch       = branches[head];
  assign ctrl.head_mispredicted = mispredicts[head];
  assign ctrl.next_branch       = branches[head_plus_one];
  assign ctrl.next_mispredicted = mispredicts[head_plus_one];

  // operand reads, forwarding comes from the entries
  assign inst1_rega_value = values[inst1_rega_tag];
  assign inst1_regb_value = values[inst1_regb_tag];
  assign inst2_rega_value = values[inst2_rega_tag];
  assign inst2_regb_value = values[inst2_regb_tag];

  // retire ports read at head and head+1
  assign retire1_dest = ctrl.retire1_en ? dests[head] : rob_pkg::ZERO_REG;
  assign retire1_value = ctrl.retire1_en ? values[head] : '0;
  assign retire1_branch = ctrl.retire1_en ? branches[head] : rob_pkg::BRANCH_NONE;
  assign retire1_mispredicted = ctrl.retire1_en && mispredicts[head];
  assign retire2_dest = ctrl.retire2_en ? dests[head_plus_one] : rob_pkg::ZERO_REG;
  assign retire2_value = ctrl.retire2_en ? values[head_plus_one] : '0;
  assign retire2_branch = ctrl.retire2_en ? branches[head_plus_one] : rob_pkg::BRANCH_NONE;
  assign retire2_mispredicted = ctrl.retire2_en && mispredicts[head_plus_one];

endmodule

/* design/rob_pkg.sv */
/*
  Shared types for the reorder buffer.
  The entry count is a module parameter and is not defined here.
*/
package rob_pkg;

  ////////////////////////////////////////
  // data widths
  ////////////////////////////////////////

  // result and operand values
  typedef logic [63:0] word_t;

  // architectural register number
  typedef logic [4:0] arch_reg_t;

  // destination shown on an idle retire port
  localparam arch_reg_t ZERO_REG = 5'd31;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // per-entry lifecycle, the fourth code is never entered
  typedef enum logic [1:0] {
    ROBE_EMPTY    = 2'b00,
    ROBE_INUSE    = 2'b01,
    ROBE_COMPLETE = 2'b10
  } entry_state_t;

  // branch outcome reported with a CDB result
  typedef enum logic [1:0] {
    BRANCH_NONE      = 2'b00,
    BRANCH_TAKEN     = 2'b01,
    BRANCH_NOT_TAKEN = 2'b10,
    BRANCH_HALT      = 2'b11
  } branch_kind_t;

endpackage

/* design/rob_pointer_control.sv */
/*
  Head and tail pointers, dispatch tags and the retire decision.
  Dispatch is dropped without notice while rob_full is high.
  NUM_ENTRIES need not be a power of two, but it must be at least 4.
*/
module rob_pointer_control #(
  parameter int NUM_ENTRIES = 32,
  localparam int TAG_W = $clog2(NUM_ENTRIES)
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               inst1_valid,
  input  logic               inst2_valid,
  input  rob_pkg::arch_reg_t inst1_dest,
  input  rob_pkg::arch_reg_t inst2_dest,
  output logic [TAG_W-1:0]   head,
  output logic [TAG_W-1:0]   inst1_tag,
  output logic [TAG_W-1:0]   inst2_tag,
  output logic               inst1_tag_valid,
  output logic               inst2_tag_valid,
  output logic               retire1_valid,
  output logic               retire2_valid,
  output logic [TAG_W-1:0]   retire1_tag,
  output logic [TAG_W-1:0]   retire2_tag,
  output logic               rob_full,
  output logic               rob_empty,
  rob_ctrl_if.ctrl           ctrl
);

  localparam logic [TAG_W-1:0] LAST = TAG_W'(NUM_ENTRIES - 1);

  logic [TAG_W-1:0] tail;
  logic [TAG_W-1:0] head_plus_one;
  logic [TAG_W-1:0] head_plus_two;
  logic [TAG_W-1:0] tail_plus_one;
  logic [TAG_W-1:0] tail_plus_two;
  logic             accept1;
  logic             accept2;

  // wrap by compare, not by overflow
  assign head_plus_one = (head == LAST) ? '0 : head + 1'b1;
  assign head_plus_two = (head_plus_one == LAST) ? '0 : head_plus_one + 1'b1;
  assign tail_plus_one = (tail == LAST) ? '0 : tail + 1'b1;
  assign tail_plus_two = (tail_plus_one == LAST) ? '0 : tail_plus_one + 1'b1;

  ////////////////////////////////////////
  // dispatch
  ////////////////////////////////////////
  assign rob_full = (ctrl.states[tail_plus_one] != rob_pkg::ROBE_EMPTY) ||
                    (ctrl.states[tail_plus_two] != rob_pkg::ROBE_EMPTY);
  assign accept1  = inst1_valid && !rob_full;
  assign accept2  = inst2_valid && !rob_full;

  // a lone inst2 takes the first free slot
  assign inst1_tag       = tail_plus_one;
  assign inst2_tag       = accept1 ? tail_plus_two : tail_plus_one;
  assign inst1_tag_valid = accept1;
  assign inst2_tag_valid = accept2;

  assign ctrl.slot1_en   = accept1;
  assign ctrl.slot1_tag  = inst1_tag;
  assign ctrl.slot1_dest = inst1_dest;
  assign ctrl.slot2_en   = accept2;
  assign ctrl.slot2_tag  = inst2_tag;
  assign ctrl.slot2_dest = inst2_dest;

  ////////////////////////////////////////
  // retire
  ////////////////////////////////////////
  // the pair retires only behind a plain, correctly predicted head
  assign retire1_valid = (ctrl.states[head] == rob_pkg::ROBE_COMPLETE);
  assign retire2_valid = retire1_valid &&
                         (ctrl.states[head_plus_one] == rob_pkg::ROBE_COMPLETE) &&
                         (ctrl.head_branch == rob_pkg::BRANCH_NONE) &&
                         !ctrl.head_mispredicted &&
                         (ctrl.next_branch != rob_pkg::BRANCH_HALT) &&
                         !ctrl.next_mispredicted;
  assign retire1_tag     = head;
  assign retire2_tag     = head_plus_one;
  assign ctrl.retire1_en = retire1_valid;
  assign ctrl.retire2_en = retire2_valid;

  always_comb
  begin
    rob_empty = 1'b1;
    for (int i = 0; i < NUM_ENTRIES; i++)
    begin
      if (ctrl.states[i] != rob_pkg::ROBE_EMPTY)
      begin
        rob_empty = 1'b0;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head <= '0;
      tail <= LAST;
    end
    else
    begin
      if (retire1_valid)
      begin
        head <= retire2_valid ? head_plus_two : head_plus_one;
      end
      if (accept1 || accept2)
      begin
        tail <= (accept1 && accept2) ? tail_plus_two : tail_plus_one;
      end
    end
  end

endmodule

/* files.f */
design/rob_pkg.sv
design/rob_cdb_if.sv
design/rob_ctrl_if.sv
design/rob_entry.sv
design/rob_entry_array.sv
design/rob_pointer_control.sv
design/reorder_buffer.sv
verification/rob_tb.sv

/* verification/rob_tb.sv */
/*
  Directed testbench for the reorder buffer with 8 entries.
  A queue model predicts tags, retirement, full and empty on every cycle.
*/
module rob_tb;

  localparam int NUM_ENTRIES = 8;
  localparam int TAG_W = $clog2(NUM_ENTRIES);
  // the directed tests need well under 150 cycles
  localparam int MAX_CYCLES = 600;

  typedef logic [TAG_W-1:0] tag_t;

  typedef struct packed {
    tag_t                  tag;
    rob_pkg::arch_reg_t    dest;
    logic                  done;
    rob_pkg::word_t        value;
    rob_pkg::branch_kind_t branch;
    logic                  mispredicted;
  } model_entry_t;

  logic clock, reset, inst1_valid, inst2_valid;
  rob_pkg::arch_reg_t inst1_dest, inst2_dest;
  tag_t inst1_rega_tag, inst1_regb_tag, inst2_rega_tag, inst2_regb_tag;
  logic cdb1_valid, cdb1_mispredicted, cdb2_valid, cdb2_mispredicted;
  tag_t cdb1_tag, cdb2_tag;
  rob_pkg::word_t cdb1_value, cdb2_value;
  rob_pkg::branch_kind_t cdb1_branch, cdb2_branch;
  tag_t inst1_tag, inst2_tag, retire1_tag, retire2_tag;
  logic inst1_tag_valid, inst2_tag_valid, retire1_valid, retire2_valid;
  rob_pkg::word_t inst1_rega_value, inst1_regb_value, inst2_rega_value, inst2_regb_value;
  rob_pkg::arch_reg_t retire1_dest, retire2_dest;
  rob_pkg::word_t retire1_value, retire2_value;
  rob_pkg::branch_kind_t retire1_branch, retire2_branch;
  logic retire1_mispredicted, retire2_mispredicted, rob_full, rob_empty;

  // model of the buffer contents, oldest first
  model_entry_t model[$];
  tag_t next_tag = '0;
  rob_pkg::word_t rng_state = 64'd55266;
  int cycles = 0;

  reorder_buffer #(.NUM_ENTRIES(NUM_ENTRIES)) u_reorder_buffer (.*);

  initial
  begin
    clock = 1'b0;
    forever
    begin
      #4 clock = ~clock;
    end
  end

  always @(posedge clock)
  begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: the run went past %0d cycles", MAX_CYCLES);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  // xorshift64 for CDB values and destinations
  function rob_pkg::word_t next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////
  task automatic report_mismatch(string name, logic [63:0] actual, logic [63:0] expected);
    $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
    $display("test failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic check_word(string name, rob_pkg::word_t actual, rob_pkg::word_t expected);
    if (actual !== expected)
    begin
      report_mismatch(name, actual, expected);
    end
  endtask

  task automatic check_reg(string name, rob_pkg::arch_reg_t actual,
                           rob_pkg::arch_reg_t expected);
    if (actual !== expected)
    begin
      report_mismatch(name, 64'(actual), 64'(expected));
    end
  endtask

  task automatic check_tag(string name, tag_t actual, tag_t expected);
    if (actual !== expected)
    begin
      report_mismatch(name, 64'(actual), 64'(expected));
    end
  endtask

  task automatic check_bit(string name, logic actual, logic expected);
    if (actual !== expected)
    begin
      report_mismatch(name, 64'(actual), 64'(expected));
    end
  endtask

  task automatic check_branch(string name, rob_pkg::branch_kind_t actual,
                              rob_pkg::branch_kind_t expected);
    if (actual !== expected)
    begin
      report_mismatch(name, 64'(actual), 64'(expected));
    end
  endtask

  task automatic check_retire(string port, logic active, tag_t tag, rob_pkg::arch_reg_t dest,
                              rob_pkg::word_t value, rob_pkg::branch_kind_t branch,
                              logic mispredicted, model_entry_t expected);
    if (active)
    begin
      check_tag({port, "_tag"}, tag, expected.tag);
      check_reg({port, "_dest"}, dest, expected.dest);
      check_word({port, "_value"}, value, expected.value);
      check_branch({port, "_branch"}, branch, expected.branch);
      check_bit({port, "_mispredicted"}, mispredicted, expected.mispredicted);
    end
    else
    begin
      // idle retire ports show the zero register and zero data
      check_reg({port, "_dest"}, dest, rob_pkg::ZERO_REG);
      check_word({port, "_value"}, value, '0);
      check_branch({port, "_branch"}, branch, rob_pkg::BRANCH_NONE);
      check_bit({port, "_mispredicted"}, mispredicted, 1'b0);
    end
  endtask

  ////////////////////////////////////////
  // model bookkeeping
  ////////////////////////////////////////
  task automatic push_dispatched(rob_pkg::arch_reg_t dest);
    model_entry_t entry;
    entry = '0;
    entry.tag = next_tag;
    entry.dest = dest;
    model.push_back(entry);
    next_tag = (next_tag == tag_t'(NUM_ENTRIES - 1)) ? '0 : next_tag + 1'b1;
  endtask

  task automatic mark_complete(tag_t tag, rob_pkg::word_t value,
                               rob_pkg::branch_kind_t branch, logic mispredicted);
    model_entry_t entry;
    foreach (model[k])
    begin
      entry = model[k];
      if (entry.tag == tag && !entry.done)
      begin
        entry.done = 1'b1;
        entry.value = value;
        entry.branch = branch;
        entry.mispredicted = mispredicted;
        model[k] = entry;
      end
    end
  endtask

  // called at the falling edge, checks this cycle and moves to the next
  task automatic account_cycle();
    logic full_exp;
    logic retire1_exp;
    logic retire2_exp;
    logic accept1;
    logic accept2;
    model_entry_t head_entry;
    model_entry_t next_entry;
    head_entry = (model.size() > 0) ? model[0] : '0;
    next_entry = (model.size() > 1) ? model[1] : '0;
    full_exp = (model.size() > NUM_ENTRIES - 2);
    check_bit("rob_full", rob_full, full_exp);
    check_bit("rob_empty", rob_empty, model.size() == 0);
    // pair retires only behind a plain head and before a non-halt, well predicted entry
    retire1_exp = (model.size() > 0) && head_entry.done;
    retire2_exp = retire1_exp && (model.size() > 1) && next_entry.done &&
                  (head_entry.branch == rob_pkg::BRANCH_NONE) && !head_entry.mispredicted &&
                  (next_entry.branch != rob_pkg::BRANCH_HALT) && !next_entry.mispredicted;
    check_bit("retire1_valid", retire1_valid, retire1_exp);
    check_bit("retire2_valid", retire2_valid, retire2_exp);
    check_retire("retire1", retire1_exp, retire1_tag, retire1_dest, retire1_value,
                 retire1_branch, retire1_mispredicted, head_entry);
    check_retire("retire2", retire2_exp, retire2_tag, retire2_dest, retire2_value,
                 retire2_branch, retire2_mispredicted, next_entry);
    accept1 = inst1_valid && !full_exp;
    accept2 = inst2_valid && !full_exp;
    check_bit("inst1_tag_valid", inst1_tag_valid, accept1);
    check_bit("inst2_tag_valid", inst2_tag_valid, accept2);
    if (retire1_exp)
    begin
      void'(model.pop_front());
    end
    if (retire2_exp)
    begin
      void'(model.pop_front());
    end
    if (accept1)
    begin
      check_tag("inst1_tag", inst1_tag, next_tag);
      push_dispatched(inst1_dest);
    end
    if (accept2)
    begin
      check_tag("inst2_tag", inst2_tag, next_tag);
      push_dispatched(inst2_dest);
    end
    // port 1 is applied first so that it wins a tie
    if (cdb1_valid)
    begin
      mark_complete(cdb1_tag, cdb1_value, cdb1_branch, cdb1_mispredicted);
    end
    if (cdb2_valid)
    begin
      mark_complete(cdb2_tag, cdb2_value, cdb2_branch, cdb2_mispredicted);
    end
    @(posedge clock);
    #1;
    inst1_valid = 1'b0;
    inst2_valid = 1'b0;
    cdb1_valid = 1'b0;
    cdb2_valid = 1'b0;
  endtask

  task automatic step_cycle();
    @(negedge clock);
    account_cycle();
  endtask

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic dispatch(logic valid1, logic valid2);
    inst1_valid = valid1;
    inst1_dest = rob_pkg::arch_reg_t'(next_random());
    inst2_valid = valid2;
    inst2_dest = rob_pkg::arch_reg_t'(next_random());
    step_cycle();
  endtask

  task automatic drive_cdb(int port, tag_t tag, rob_pkg::branch_kind_t branch,
                           logic mispredicted);
    if (port == 1)
    begin
      cdb1_valid = 1'b1;
      cdb1_tag = tag;
      cdb1_value = next_random();
      cdb1_branch = branch;
      cdb1_mispredicted = mispredicted;
    end
    else
    begin
      cdb2_valid = 1'b1;
      cdb2_tag = tag;
      cdb2_value = next_random();
      cdb2_branch = branch;
      cdb2_mispredicted = mispredicted;
    end
  endtask

  // completes up to two pending entries per cycle until the buffer is empty
  task automatic complete_and_drain();
    int port;
    while (model.size() > 0)
    begin
      port = 1;
      foreach (model[k])
      begin
        if (!model[k].done && port <= 2)
        begin
          drive_cdb(port, model[k].tag, rob_pkg::BRANCH_NONE, 1'b0);
          port++;
        end
      end
      step_cycle();
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////
  task automatic test_reset();
    // empty model, so every status output is expected idle
    step_cycle();
  endtask

  task automatic test_dispatch_tags();
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b1);
    dispatch(1'b0, 1'b1);
    complete_and_drain();
  endtask

  task automatic test_out_of_order();
    tag_t t[4];
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b1);
    for (int k = 0; k < 4; k++)
    begin
      t[k] = model[k].tag;
    end
    drive_cdb(1, t[3], rob_pkg::BRANCH_NONE, 1'b0);
    drive_cdb(2, t[1], rob_pkg::BRANCH_NONE, 1'b0);
    step_cycle();
    // both ports on one entry
    drive_cdb(1, t[2], rob_pkg::BRANCH_NONE, 1'b0);
    drive_cdb(2, t[2], rob_pkg::BRANCH_NOT_TAKEN, 1'b1);
    step_cycle();
    drive_cdb(2, t[0], rob_pkg::BRANCH_NONE, 1'b0);
    step_cycle();
    complete_and_drain();
  endtask

  task automatic test_retire_rule();
    tag_t t[6];
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b1);
    for (int k = 0; k < 6; k++)
    begin
      t[k] = model[k].tag;
    end
    drive_cdb(1, t[1], rob_pkg::BRANCH_NONE, 1'b0);
    drive_cdb(2, t[2], rob_pkg::BRANCH_HALT, 1'b0);
    step_cycle();
    drive_cdb(1, t[3], rob_pkg::BRANCH_NONE, 1'b0);
    drive_cdb(2, t[4], rob_pkg::BRANCH_NOT_TAKEN, 1'b1);
    step_cycle();
    // taken head last, then six single retirements
    drive_cdb(1, t[5], rob_pkg::BRANCH_NONE, 1'b0);
    drive_cdb(2, t[0], rob_pkg::BRANCH_TAKEN, 1'b0);
    step_cycle();
    complete_and_drain();
  endtask

  task automatic test_operand_reads();
    tag_t stored_tag;
    tag_t forward_tag;
    rob_pkg::word_t stored_value;
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b0);
    // the head stays in use so the stored result is not retired
    stored_tag = model[1].tag;
    forward_tag = model[2].tag;
    drive_cdb(1, stored_tag, rob_pkg::BRANCH_NONE, 1'b0);
    stored_value = cdb1_value;
    step_cycle();
    inst1_rega_tag = stored_tag;
    inst1_regb_tag = forward_tag;
    inst2_rega_tag = forward_tag;
    inst2_regb_tag = stored_tag;
    drive_cdb(2, forward_tag, rob_pkg::BRANCH_NONE, 1'b0);
    @(negedge clock);
    check_word("inst1_rega_value", inst1_rega_value, stored_value);
    check_word("inst1_regb_value", inst1_regb_value, cdb2_value);
    check_word("inst2_rega_value", inst2_rega_value, cdb2_value);
    check_word("inst2_regb_value", inst2_regb_value, stored_value);
    account_cycle();
    complete_and_drain();
  endtask

  task automatic test_full();
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b1);
    dispatch(1'b1, 1'b0);
    // occupancy is NUM_ENTRIES - 1, this pair must be dropped
    dispatch(1'b1, 1'b1);
    complete_and_drain();
    dispatch(1'b1, 1'b1);
    complete_and_drain();
  endtask

  initial
  begin
    reset = 1'b1;
    inst1_valid = 1'b0;
    inst2_valid = 1'b0;
    inst1_dest = '0;
    inst2_dest = '0;
    inst1_rega_tag = '0;
    inst1_regb_tag = '0;
    inst2_rega_tag = '0;
    inst2_regb_tag = '0;
    cdb1_valid = 1'b0;
    cdb1_tag = '0;
    cdb1_value = '0;
    cdb1_branch = rob_pkg::BRANCH_NONE;
    cdb1_mispredicted = 1'b0;
    cdb2_valid = 1'b0;
    cdb2_tag = '0;
    cdb2_value = '0;
    cdb2_branch = rob_pkg::BRANCH_NONE;
    cdb2_mispredicted = 1'b0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    test_reset();
    test_dispatch_tags();
    test_out_of_order();
    test_retire_rule();
    test_operand_reads();
    test_full();
    step_cycle();
    $display("test passed");
    $finish;
  end

endmodule
